// File: design/memMuxPkg.sv
`default_nettype none

package memMuxPkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	localparam int numClients = 5;
	localparam int addrW = 45;
	localparam int dataW = 64;
	localparam int beW = 8;
	localparam int localTagW = 13;
	localparam int chanW = 3;
	localparam int fifoDepth = 16;
	localparam int fifoCntW = 4;

	// sdram sits between the two address limits
	localparam logic [addrW-1:0] flashLimit = 45'h040000000;
	localparam logic [addrW-1:0] ioBase = 45'h1FFFFFFF0000;

	// --------------------------------------------------
	// encodings
	// --------------------------------------------------
	typedef enum logic {
		cmdWrite = 1'b0,
		cmdRead = 1'b1
	} busCmd_t;

	typedef enum logic [1:0] {
		sizeByte,
		sizeHalf,
		sizeWord,
		sizeDword
	} accessSize_t;

	typedef enum logic [1:0] {
		tgtFlash,
		tgtSdram,
		tgtIo
	} memTarget_t;

	// --------------------------------------------------
	// bundles
	// --------------------------------------------------
	typedef struct packed {
		logic [2:0] offset;
		accessSize_t size;
		logic [chanW-1:0] channel;
		logic [localTagW-1:0] localTag;
	} busTag_t;

	typedef struct packed {
		busCmd_t cmd;
		accessSize_t size;
		logic [addrW-1:0] addr;
		logic [dataW-1:0] data;
		logic [localTagW-1:0] tag;
	} clientReq_t;

	typedef struct packed {
		busCmd_t cmd;
		logic [addrW-1:0] addr;
		logic [beW-1:0] be;
		busTag_t tag;
		logic [dataW-1:0] data;
	} busReq_t;

	typedef struct packed {
		busTag_t tag;
		logic [dataW-1:0] data;
	} retBeat_t;

	typedef struct packed {
		logic [dataW-1:0] data;
		logic [localTagW-1:0] tag;
		accessSize_t size;
	} clientRet_t;

endpackage : memMuxPkg

`default_nettype wire

// File: design/requestArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module requestArbiter import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire [numClients-1:0] clientAct,
	input wire clientReq_t clientReq [numClients],
	input wire flashNext,
	input wire sdramNext,
	input wire ioNext,
	output logic [numClients-1:0] clientNext,
	output busReq_t busReq,
	output logic flashAct,
	output logic sdramAct,
	output logic ioAct
);

	logic issueFree;
	logic anyAct;
	logic blocked;
	logic [chanW-1:0] grantChan;
	clientReq_t selReq;
	logic [beW-1:0] fieldMask;
	busReq_t nextReq;
	memTarget_t nextTarget;

	// --------------------------------------------------
	// handshake and priority grant
	// --------------------------------------------------
	always_comb begin
		// issue register empties when its target takes the command
		issueFree = ~(flashAct | sdramAct | ioAct) | (flashAct & flashNext) |
			(sdramAct & sdramNext) | (ioAct & ioNext);
		anyAct = |clientAct;
		blocked = 1'b0;
		for (int i = 0; i < numClients; i++) begin
			clientNext[i] = issueFree & ~blocked;
			blocked = blocked | clientAct[i];
		end
	end

	// lowest active index wins
	always_comb begin
		grantChan = '0;
		for (int i = numClients - 1; i >= 0; i--) begin
			if (clientAct[i])
				grantChan = chanW'(i);
		end
		selReq = clientReq[grantChan];
	end

	// --------------------------------------------------
	// command encoding
	// --------------------------------------------------
	always_comb begin
		// ones over the naturally aligned field
		case (selReq.size)
			sizeByte: fieldMask = 8'h01 << selReq.addr[2:0];
			sizeHalf: fieldMask = 8'h03 << {selReq.addr[2:1], 1'b0};
			sizeWord: fieldMask = 8'h0F << {selReq.addr[2], 2'b00};
			default: fieldMask = 8'hFF;
		endcase

		nextReq.cmd = selReq.cmd;
		nextReq.addr = selReq.addr;
		nextReq.be = ~fieldMask;
		nextReq.tag.offset = selReq.addr[2:0];
		nextReq.tag.size = selReq.size;
		nextReq.tag.channel = grantChan;
		nextReq.tag.localTag = selReq.tag;

		// write data copied over every lane of its size
		case (selReq.size)
			sizeByte: nextReq.data = {8{selReq.data[7:0]}};
			sizeHalf: nextReq.data = {4{selReq.data[15:0]}};
			sizeWord: nextReq.data = {2{selReq.data[31:0]}};
			default: nextReq.data = selReq.data;
		endcase

		// former system window falls into io
		if (selReq.addr < flashLimit)
			nextTarget = tgtFlash;
		else if (selReq.addr < ioBase)
			nextTarget = tgtSdram;
		else
			nextTarget = tgtIo;
	end

	// --------------------------------------------------
	// issue register
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			flashAct <= 1'b0;
			sdramAct <= 1'b0;
			ioAct <= 1'b0;
		end else if (issueFree) begin
			flashAct <= anyAct & (nextTarget == tgtFlash);
			sdramAct <= anyAct & (nextTarget == tgtSdram);
			ioAct <= anyAct & (nextTarget == tgtIo);
		end
	end

	// command stays put until accepted
	always_ff @(posedge CLK) begin
		if (issueFree & anyAct)
			busReq <= nextReq;
	end

endmodule : requestArbiter

`default_nettype wire

// File: design/returnFifo.sv
`timescale 1ns/100ps
`default_nettype none

module returnFifo import memMuxPkg::*; #(
	parameter int depth = 16
) (
	input wire CLK,
	input wire RESETn,
	input wire write,
	input wire retBeat_t writeBeat,
	input wire read,
	output retBeat_t readBeat,
	output logic empty,
	output logic [$clog2(depth)-1:0] used
);

	localparam int ptrW = $clog2(depth);
	localparam logic [ptrW:0] fullCount = (ptrW + 1)'(depth);

	retBeat_t mem [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [ptrW:0] count;
	logic doWrite;
	logic doRead;

	assign doRead = read & ~empty;
	assign doWrite = write & (count != fullCount);
	assign empty = (count == '0);
	// a full fifo reports the top count
	assign used = (count == fullCount) ? '1 : count[ptrW-1:0];
	assign readBeat = mem[rdPtr];

	always_ff @(posedge CLK) begin
		if (doWrite)
			mem[wrPtr] <= writeBeat;
	end

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule : returnFifo

`default_nettype wire

// File: design/returnMerger.sv
`timescale 1ns/100ps
`default_nettype none

module returnMerger import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire sdramRdy,
	input wire retBeat_t sdramRet,
	input wire retBeat_t flashBeat,
	input wire retBeat_t ioBeat,
	input wire flashEmpty,
	input wire ioEmpty,
	input wire [fifoCntW-1:0] flashUsed,
	input wire [fifoCntW-1:0] ioUsed,
	output logic flashRead,
	output logic ioRead,
	output retBeat_t merged,
	output logic mergedValid
);

	logic ioFirst;

	// --------------------------------------------------
	// source select
	// --------------------------------------------------
	always_comb begin
		// fuller fifo goes first and io wins a tie
		ioFirst = ~ioEmpty & (flashEmpty | (ioUsed >= flashUsed));

		// sdram beats have no buffer, so they always win
		ioRead = ~sdramRdy & ioFirst;
		flashRead = ~sdramRdy & ~flashEmpty & ~ioFirst;
	end

	// --------------------------------------------------
	// merged beat register
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn)
			mergedValid <= 1'b0;
		else
			mergedValid <= sdramRdy | ioRead | flashRead;
	end

	always_ff @(posedge CLK) begin
		if (sdramRdy)
			merged <= sdramRet;
		else if (ioRead)
			merged <= ioBeat;
		else if (flashRead)
			merged <= flashBeat;
	end

endmodule : returnMerger

`default_nettype wire

// File: design/returnAligner.sv
`timescale 1ns/100ps
`default_nettype none

module returnAligner import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,
	input wire retBeat_t merged,
	input wire mergedValid,
	output logic [numClients-1:0] clientRdy,
	output clientRet_t clientRet
);

	logic [dataW-1:0] shifted;
	logic [dataW-1:0] aligned;

	// move the addressed field down to bit 0
	always_comb begin
		case (merged.tag.size)
			sizeByte: begin
				shifted = merged.data >> {merged.tag.offset, 3'b000};
				aligned = {{(dataW - 8){1'b0}}, shifted[7:0]};
			end
			sizeHalf: begin
				shifted = merged.data >> {merged.tag.offset[2:1], 4'b0000};
				aligned = {{(dataW - 16){1'b0}}, shifted[15:0]};
			end
			sizeWord: begin
				shifted = merged.data >> {merged.tag.offset[2], 5'b00000};
				aligned = {{(dataW - 32){1'b0}}, shifted[31:0]};
			end
			default: begin
				shifted = merged.data;
				aligned = shifted;
			end
		endcase
	end

	// --------------------------------------------------
	// requester strobes
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			clientRdy <= '0;
		end else begin
			for (int i = 0; i < numClients; i++)
				clientRdy[i] <= mergedValid & (merged.tag.channel == chanW'(i));
		end
	end

	always_ff @(posedge CLK) begin
		if (mergedValid) begin
			clientRet.data <= aligned;
			clientRet.tag <= merged.tag.localTag;
			clientRet.size <= merged.tag.size;
		end
	end

endmodule : returnAligner

`default_nettype wire

// File: design/memMux.sv
`timescale 1ns/100ps
`default_nettype none

module memMux import memMuxPkg::*; (
	input wire CLK,
	input wire RESETn,

	// requester side
	input wire [numClients-1:0] clientAct,
	output logic [numClients-1:0] clientNext,
	input wire clientReq_t clientReq [numClients],
	output logic [numClients-1:0] clientRdy,
	output clientRet_t clientRet,

	// target side
	output busReq_t busReq,
	input wire flashNext,
	input wire sdramNext,
	input wire ioNext,
	output logic flashAct,
	output logic sdramAct,
	output logic ioAct,
	input wire flashRdy,
	input wire sdramRdy,
	input wire ioRdy,
	input wire retBeat_t flashRet,
	input wire retBeat_t sdramRet,
	input wire retBeat_t ioRet
);

	retBeat_t flashHead;
	retBeat_t ioHead;
	logic flashEmpty;
	logic ioEmpty;
	logic flashRead;
	logic ioRead;
	logic [fifoCntW-1:0] flashUsed;
	logic [fifoCntW-1:0] ioUsed;
	retBeat_t merged;
	logic mergedValid;

	// --------------------------------------------------
	// request path
	// --------------------------------------------------
	requestArbiter arbiter (
		.CLK(CLK),
		.RESETn(RESETn),
		.clientAct(clientAct),
		.clientReq(clientReq),
		.flashNext(flashNext),
		.sdramNext(sdramNext),
		.ioNext(ioNext),
		.clientNext(clientNext),
		.busReq(busReq),
		.flashAct(flashAct),
		.sdramAct(sdramAct),
		.ioAct(ioAct)
	);

	// --------------------------------------------------
	// return path
	// --------------------------------------------------
	returnFifo #(.depth(fifoDepth)) flashFifo (
		.CLK(CLK),
		.RESETn(RESETn),
		.write(flashRdy),
		.writeBeat(flashRet),
		.read(flashRead),
		.readBeat(flashHead),
		.empty(flashEmpty),
		.used(flashUsed)
	);

	returnFifo #(.depth(fifoDepth)) ioFifo (
		.CLK(CLK),
		.RESETn(RESETn),
		.write(ioRdy),
		.writeBeat(ioRet),
		.read(ioRead),
		.readBeat(ioHead),
		.empty(ioEmpty),
		.used(ioUsed)
	);

	returnMerger merger (
		.CLK(CLK),
		.RESETn(RESETn),
		.sdramRdy(sdramRdy),
		.sdramRet(sdramRet),
		.flashBeat(flashHead),
		.ioBeat(ioHead),
		.flashEmpty(flashEmpty),
		.ioEmpty(ioEmpty),
		.flashUsed(flashUsed),
		.ioUsed(ioUsed),
		.flashRead(flashRead),
		.ioRead(ioRead),
		.merged(merged),
		.mergedValid(mergedValid)
	);

	returnAligner aligner (
		.CLK(CLK),
		.RESETn(RESETn),
		.merged(merged),
		.mergedValid(mergedValid),
		.clientRdy(clientRdy),
		.clientRet(clientRet)
	);

endmodule : memMux

`default_nettype wire

// File: verification/memMuxTb.sv
`timescale 1ns/100ps
`default_nettype none

module memMuxTb import memMuxPkg::*; ();

	localparam int numTrans = 300;
	localparam int cycleLimit = numTrans * 40;
	localparam int maxOut = 10;
	localparam int tagSpace = 1 << localTagW;

	logic CLK = 1'b0;
	logic RESETn = 1'b0;
	logic [numClients-1:0] clientAct = '0;
	clientReq_t clientReq [numClients] = '{default: '0};
	wire [numClients-1:0] clientNext;
	wire [numClients-1:0] clientRdy;
	clientRet_t clientRet;
	busReq_t busReq;
	// targets indexed flash, sdram, io
	wire [2:0] tgtAct;
	logic [2:0] tgtNext = '0;
	logic [2:0] tgtRdy = '0;
	retBeat_t tgtRet [3] = '{default: '0};

	clientReq_t stim [numClients][numTrans];
	int stimCount [numClients] = '{default: 0};
	int stimPtr [numClients] = '{default: 0};
	clientRet_t expRet [tagSpace];
	int expChan [tagSpace];
	logic isSdram [tagSpace];
	logic pending [tagSpace] = '{default: 1'b0};
	int rdyCycle [tagSpace];
	busReq_t expReqQ [$];
	memTarget_t expTgtQ [$];
	busTag_t tgtTag [3][maxOut];
	logic [addrW-1:0] tgtAddr [3][maxOut];
	int tgtDue [3][maxOut];
	int tgtCnt [3] = '{default: 0};
	logic [31:0] rng = 32'h9841dbf5;
	int cycle = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	int issuedReads = 0;
	int returnedReads = 0;
	int outstanding = 0;
	int nextTag = 0;
	logic running = 1'b0;

	memMux memMux_inst (
		.CLK(CLK),
		.RESETn(RESETn),
		.clientAct(clientAct),
		.clientNext(clientNext),
		.clientReq(clientReq),
		.clientRdy(clientRdy),
		.clientRet(clientRet),
		.busReq(busReq),
		.flashNext(tgtNext[0]),
		.sdramNext(tgtNext[1]),
		.ioNext(tgtNext[2]),
		.flashAct(tgtAct[0]),
		.sdramAct(tgtAct[1]),
		.ioAct(tgtAct[2]),
		.flashRdy(tgtRdy[0]),
		.sdramRdy(tgtRdy[1]),
		.ioRdy(tgtRdy[2]),
		.flashRet(tgtRet[0]),
		.sdramRet(tgtRet[1]),
		.ioRet(tgtRet[2])
	);

	always #20 CLK = ~CLK;

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// every address bit above the offset reaches the pattern
	function automatic logic [dataW-1:0] patternOf(input logic [addrW-4:0] a);
		return {a, 22'h0} ^ {22'h2B5A3C, a} ^ 64'h5DEECE66D0F1A2B3;
	endfunction

	function automatic int bytesOf(input accessSize_t s);
		return 1 << int'(s);
	endfunction

	function automatic memTarget_t expectTarget(input logic [addrW-1:0] addr);
		if (addr < flashLimit)
			return tgtFlash;
		if (addr < ioBase)
			return tgtSdram;
		return tgtIo;
	endfunction

	function automatic busReq_t expectReq(input clientReq_t req, input int chan);
		busReq_t r;
		int n;
		int base;
		n = bytesOf(req.size);
		base = int'(req.addr[2:0]) & ~(n - 1);
		r.cmd = req.cmd;
		r.addr = req.addr;
		r.tag.offset = req.addr[2:0];
		r.tag.size = req.size;
		r.tag.channel = chanW'(chan);
		r.tag.localTag = req.tag;
		for (int b = 0; b < beW; b++) begin
			r.be[b] = !(b >= base && b < base + n);
			r.data[8*b +: 8] = req.data[8*(b % n) +: 8];
		end
		return r;
	endfunction

	function automatic clientRet_t expectRet(input logic [addrW-1:0] addr,
			input accessSize_t size, input logic [localTagW-1:0] tag);
		clientRet_t r;
		logic [dataW-1:0] d;
		int n;
		int base;
		d = patternOf(addr[addrW-1:3]);
		n = bytesOf(size);
		base = int'(addr[2:0]) & ~(n - 1);
		r.data = '0;
		for (int b = 0; b < n; b++)
			r.data[8*b +: 8] = d[8*(base + b) +: 8];
		r.tag = tag;
		r.size = size;
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [159:0] expected,
			input logic [159:0] actual);
		if (expected !== actual) begin
			valueErrors++;
			$display("FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic reportError(input string msg);
		otherErrors++;
		$display("ERROR %s", msg);
	endtask

	task automatic addStim(input int c, input busCmd_t cmd, input accessSize_t size,
			input logic [addrW-1:0] addr);
		clientReq_t r;
		rng = xorshift(rng);
		r.cmd = cmd;
		r.size = size;
		r.addr = addr;
		r.data = {rng, ~rng};
		r.tag = localTagW'(nextTag);
		stim[c][stimCount[c]] = r;
		stimCount[c]++;
		nextTag++;
	endtask

	function automatic logic allIssued();
		for (int i = 0; i < numClients; i++) begin
			if (stimPtr[i] < stimCount[i])
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// --------------------------------------------------
	// requester driver and grant order check
	// --------------------------------------------------
	always @(posedge CLK) begin
		int lowest;
		int moved;
		int nMoved;
		clientReq_t r;
		lowest = -1;
		moved = -1;
		nMoved = 0;
		if (running) begin
			for (int i = numClients - 1; i >= 0; i--) begin
				if (clientAct[i])
					lowest = i;
			end
			for (int i = 0; i < numClients; i++) begin
				if (clientAct[i] && clientNext[i]) begin
					moved = i;
					nMoved++;
					r = clientReq[i];
					expReqQ.push_back(expectReq(r, i));
					expTgtQ.push_back(expectTarget(r.addr));
					if (r.cmd == cmdRead) begin
						expRet[r.tag] = expectRet(r.addr, r.size, r.tag);
						expChan[r.tag] = i;
						isSdram[r.tag] = (expectTarget(r.addr) == tgtSdram);
						pending[r.tag] = 1'b1;
						outstanding++;
					end
					stimPtr[i]++;
				end
			end
			if (nMoved > 0) begin
				checkValue("grant count", 160'(1), 160'(nMoved));
				checkValue("grant order", 160'(lowest), 160'(moved));
			end
			for (int i = 0; i < numClients; i++) begin
				rng = xorshift(rng);
				// a waiting request holds until next
				if (!clientAct[i] || moved == i) begin
					if (stimPtr[i] < stimCount[i] &&
							(stimPtr[i] == 0 || rng[1:0] != 2'b00)) begin
						clientAct[i] <= 1'b1;
						clientReq[i] <= stim[i][stimPtr[i]];
					end else begin
						clientAct[i] <= 1'b0;
					end
				end
			end
		end
	end

	// --------------------------------------------------
	// target models
	// --------------------------------------------------
	always @(posedge CLK) begin
		int hit;
		if (tgtRdy[1])
			rdyCycle[tgtRet[1].tag.localTag] = cycle;
		for (int t = 0; t < 3; t++) begin
			if (running) begin
				if (tgtAct[t] && tgtNext[t] && busReq.cmd == cmdRead) begin
					rng = xorshift(rng);
					tgtTag[t][tgtCnt[t]] = busReq.tag;
					tgtAddr[t][tgtCnt[t]] = busReq.addr;
					tgtDue[t][tgtCnt[t]] = cycle + 1 + int'(rng[2:0]);
					tgtCnt[t]++;
				end
				hit = -1;
				for (int k = tgtCnt[t] - 1; k >= 0; k--) begin
					if (tgtDue[t][k] <= cycle)
						hit = k;
				end
				if (hit >= 0) begin
					tgtRdy[t] <= 1'b1;
					tgtRet[t] <= {tgtTag[t][hit],
						patternOf(tgtAddr[t][hit][addrW-1:3])};
					for (int k = hit; k < tgtCnt[t] - 1; k++) begin
						tgtTag[t][k] = tgtTag[t][k + 1];
						tgtAddr[t][k] = tgtAddr[t][k + 1];
						tgtDue[t][k] = tgtDue[t][k + 1];
					end
					tgtCnt[t]--;
				end else begin
					tgtRdy[t] <= 1'b0;
				end
				rng = xorshift(rng);
				tgtNext[t] <= (tgtCnt[t] < maxOut) && (rng[1:0] != 2'b00);
			end
		end
	end

	// --------------------------------------------------
	// compare processes
	// --------------------------------------------------
	always @(posedge CLK) begin
		memTarget_t t;
		logic accepted;
		accepted = 1'b0;
		t = tgtFlash;
		for (int k = 0; k < 3; k++) begin
			if (tgtAct[k] && tgtNext[k]) begin
				accepted = 1'b1;
				t = memTarget_t'(2'(k));
			end
		end
		if (running && $countones(tgtAct) > 1)
			reportError("more than one target act is high");
		if (running && accepted) begin
			if (expReqQ.size() == 0) begin
				reportError("a target accepted a command that no requester issued");
			end else begin
				checkValue("busReq command", 160'(expReqQ.pop_front()),
					160'(busReq));
				checkValue("target select", 160'(expTgtQ.pop_front()), 160'(t));
				if (busReq.cmd == cmdRead)
					issuedReads++;
			end
		end
	end

	always @(posedge CLK) begin
		logic [localTagW-1:0] tag;
		tag = clientRet.tag;
		if (running && clientRdy != '0) begin
			if (!pending[tag]) begin
				reportError("a requester got a return with no outstanding read");
			end else begin
				checkValue("return beat", 160'(expRet[tag]), 160'(clientRet));
				checkValue("return strobe", 160'(1 << expChan[tag]), 160'(clientRdy));
				if (isSdram[tag])
					checkValue("sdram return latency", 160'(rdyCycle[tag] + 2),
						160'(cycle));
				pending[tag] = 1'b0;
				outstanding--;
				returnedReads++;
			end
		end
	end

	always @(posedge CLK) begin
		cycle <= cycle + 1;
		if (cycle >= cycleLimit) begin
			reportError("the run did not finish within the cycle limit");
			$display("errors: %0d value, %0d other", valueErrors, otherErrors);
			$display("sim failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// stimulus and end of run
	// --------------------------------------------------
	initial begin
		logic [31:0] pick;
		logic [addrW-1:0] a;
		// every offset and size case as a write and then a read
		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < 8; off += (1 << s)) begin
				a = flashLimit + 45'(s * 64 + off);
				addStim(0, cmdWrite, accessSize_t'(2'(s)), a);
				addStim(0, cmdRead, accessSize_t'(2'(s)), a);
			end
		end
		// both sides of each map boundary
		addStim(1, cmdRead, sizeByte, flashLimit - 45'd1);
		addStim(1, cmdRead, sizeByte, flashLimit);
		addStim(1, cmdRead, sizeByte, ioBase - 45'd1);
		addStim(1, cmdRead, sizeByte, ioBase);
		while (nextTag < numTrans) begin
			rng = xorshift(rng);
			pick = rng;
			rng = xorshift(rng);
			case (pick[1:0])
				2'd0: a = {15'h0, rng[29:0]};
				2'd1: a = ioBase + {29'h0, rng[15:0]};
				default: a = flashLimit + {13'h0, rng};
			endcase
			addStim(int'(pick[4:2]) % numClients, busCmd_t'(pick[5]),
				accessSize_t'(pick[7:6]), a);
		end

		repeat (4) @(posedge CLK);
		checkValue("outputs in reset", 160'(0), 160'({tgtAct, clientRdy}));
		RESETn <= 1'b1;
		running <= 1'b1;
		@(posedge CLK);
		while (!(allIssued() && outstanding == 0 && expReqQ.size() == 0 && tgtAct == '0))
			@(posedge CLK);
		// catch late or duplicated returns
		repeat (20) @(posedge CLK);
		checkValue("returned read count", 160'(issuedReads), 160'(returnedReads));
		$display("errors: %0d value, %0d other, reads issued %0d, returned %0d",
			valueErrors, otherErrors, issuedReads, returnedReads);
		if (valueErrors + otherErrors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule : memMuxTb

`default_nettype wire

// File: project.f
design/memMuxPkg.sv
design/requestArbiter.sv
design/returnFifo.sv
design/returnMerger.sv
design/returnAligner.sv
design/memMux.sv
verification/memMuxTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module memMuxTb -f project.f
./obj_dir/VmemMuxTb | tee sim.log

if grep -q "sim failed" sim.log; then
	echo "testbench reported a failure, see sim.log"
	exit 1
fi
echo "testbench finished without a failure"
